// File: list.f
verilog/apb_pkg.sv
verilog/delay_pkg.sv
verilog/apb_command_master.sv
verilog/apb_delayer.sv
verilog/apb_register_file.sv
verilog/apb_delay_subsystem.sv
testbench/apb_delay_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the APB delay subsystem testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
  --top-module apb_delay_tb \
  -f list.f \
  -o apb_delay_sim

output=$(./obj_dir/apb_delay_sim)
echo "$output"

if echo "$output" | grep -qx "all tests passed"; then
  exit 0
else
  exit 1
fi

// File: testbench/apb_delay_tb.sv
`timescale 1ns/1ps

module apb_delay_tb;

  localparam int RATIO       = 5191;
  localparam int WAIT_STATES = 2;
  localparam int FRAC_BITS   = 10;
  // scaled device time plus master and delayer overhead
  localparam int LATENCY     = 4 + WAIT_STATES + ((WAIT_STATES * RATIO) >> FRAC_BITS);

  localparam int RESET_CYCLES      = 10;
  localparam int WRITE_READ_ROUNDS = 15;
  localparam int STROBE_ROUNDS     = 8;
  localparam int ERROR_ROUNDS      = 3;
  localparam int BUSY_ROUNDS       = 2;
  localparam int TRANSFERS = 2 * WRITE_READ_ROUNDS + 2 * STROBE_ROUNDS
                           + 4 * ERROR_ROUNDS + 2 * BUSY_ROUNDS;
  localparam int WAIT_LIMIT     = 4 * LATENCY;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + TRANSFERS * (LATENCY + 4) + 250;

  logic              clock;
  logic              reset;
  logic              start;
  apb_pkg::command_t command;
  logic              busy;
  logic              done;
  apb_pkg::result_t  result;

  logic [31:0] lfsr_state;
  logic [31:0] model [16];
  string       current_test;
  int          errors;
  int          transfers;
  int          cycle_count;
  int          start_edge;
  logic        in_flight;

  apb_delay_subsystem DUT (
    .clock   (clock),
    .reset   (reset),
    .start   (start),
    .command (command),
    .busy    (busy),
    .done    (done),
    .result  (result)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic take_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  function automatic apb_pkg::command_t make_command(input logic write, input logic [31:0] addr,
      input logic [31:0] wdata, input logic [3:0] strb, input logic [2:0] prot);
    apb_pkg::command_t cmd;
    cmd.write = write;
    cmd.addr  = addr;
    cmd.wdata = wdata;
    cmd.strb  = strb;
    cmd.prot  = prot;
    return cmd;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
      input logic [31:0] new_word, input logic [3:0] strb);
    logic [31:0] merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

  // one transfer, optionally with a second start while busy
  task automatic do_transfer(input apb_pkg::command_t cmd, input logic inject,
      input apb_pkg::command_t stray, input logic [31:0] exp_rdata, input logic exp_error,
      input logic check_rdata);
    int   waited;
    logic seen;
    @(negedge clock);
    start   = 1'b1;
    command = cmd;
    @(negedge clock);
    start  = 1'b0;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < WAIT_LIMIT) begin
      if (done) begin
        seen = 1'b1;
      end else begin
        if (inject && waited == 3) begin
          start   = 1'b1;
          command = stray;
        end else begin
          start = 1'b0;
        end
        @(negedge clock);
        waited++;
      end
    end
    start = 1'b0;
    transfers++;
    if (!seen) begin
      $display("%s: no done within %0d cycles", current_test, WAIT_LIMIT);
      errors++;
    end else begin
      assert (result.error == exp_error) else begin
        $display("Fail %s error: expected %0b actual %0b", current_test, exp_error,
                 result.error);
        errors++;
      end
      if (check_rdata) begin
        assert (result.rdata == exp_rdata) else begin
          $display("Fail %s rdata: expected %h actual %h", current_test, exp_rdata,
                   result.rdata);
          errors++;
        end
      end
    end
    // the done cycle still counts as busy
    if (seen && inject) begin
      start   = 1'b1;
      command = stray;
      @(negedge clock);
      start = 1'b0;
    end
  endtask

  task automatic read_check(input logic [3:0] index);
    do_transfer(make_command(1'b0, {26'd0, index, 2'b00}, '0, 4'h0, 3'b001), 1'b0, '0,
                model[index], 1'b0, 1'b1);
  endtask

  always @(posedge clock) begin
    if (reset) begin
      cycle_count <= 0;
    end else begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
        $display("run stopped after %0d cycles without finishing", cycle_count);
        $display("transfers: %0d errors: %0d", transfers, errors + 1);
        $display("tests failed");
        $finish;
      end
    end
  end

  // latency, busy level and stray done pulses
  always @(posedge clock) begin
    if (reset) begin
      in_flight <= 1'b0;
    end else if (in_flight) begin
      assert (busy) else begin
        $display("Fail %s busy: expected 1 actual %0b", current_test, busy);
        errors++;
      end
      if (done) begin
        in_flight <= 1'b0;
        assert (cycle_count - start_edge == LATENCY) else begin
          $display("Fail %s latency: expected %0d actual %0d", current_test, LATENCY,
                   cycle_count - start_edge);
          errors++;
        end
      end
    end else begin
      assert (!done) else begin
        $display("%s: done pulsed with no transfer in flight", current_test);
        errors++;
      end
      assert (!busy) else begin
        $display("Fail %s idle busy: expected 0 actual %0b", current_test, busy);
        errors++;
      end
      if (start) begin
        in_flight  <= 1'b1;
        start_edge <= cycle_count;
      end
    end
  end

  assert property (@(posedge clock) disable iff (reset) done |=> !done) else begin
    $display("Fail %s done width: expected 1 cycle actual more", current_test);
    errors++;
  end

  assert property (@(posedge clock) reset |=> (!busy && !done)) else begin
    $display("Fail reset busy done: expected 00 actual %0b%0b", busy, done);
    errors++;
  end

  initial begin
    logic [31:0] r_index;
    logic [31:0] r_data;
    logic [31:0] r_strb;
    logic [31:0] addr;
    reset        = 1'b1;
    start        = 1'b0;
    command      = '0;
    errors       = 0;
    transfers    = 0;
    lfsr_state   = 32'hcd843d43;
    current_test = "reset";
    for (int i = 0; i < 16; i++) begin
      model[i] = '0;
    end
    repeat (RESET_CYCLES) @(negedge clock);
    reset = 1'b0;

    current_test = "write_read";
    for (int i = 0; i < WRITE_READ_ROUNDS; i++) begin
      take_bits(4, r_index);
      take_bits(32, r_data);
      do_transfer(make_command(1'b1, {26'd0, r_index[3:0], 2'b00}, r_data, 4'hf, 3'b001),
                  1'b0, '0, '0, 1'b0, 1'b0);
      model[r_index[3:0]] = r_data;
      read_check(r_index[3:0]);
    end

    current_test = "byte_strobes";
    for (int i = 0; i < STROBE_ROUNDS; i++) begin
      take_bits(4, r_index);
      take_bits(32, r_data);
      take_bits(4, r_strb);
      do_transfer(make_command(1'b1, {26'd0, r_index[3:0], 2'b00}, r_data, r_strb[3:0],
                  3'b001), 1'b0, '0, '0, 1'b0, 1'b0);
      model[r_index[3:0]] = merge_bytes(model[r_index[3:0]], r_data, r_strb[3:0]);
      read_check(r_index[3:0]);
    end

    current_test = "errors";
    for (int i = 0; i < ERROR_ROUNDS; i++) begin
      take_bits(4, r_index);
      take_bits(32, r_data);
      addr = (32'd16 + r_index) << 2;
      do_transfer(make_command(1'b0, addr, '0, 4'h0, 3'b001), 1'b0, '0, '0, 1'b1, 1'b0);
      do_transfer(make_command(1'b1, addr, r_data, 4'hf, 3'b001), 1'b0, '0, '0, 1'b1, 1'b0);
      // unprivileged write must leave the word alone
      do_transfer(make_command(1'b1, {26'd0, r_index[3:0], 2'b00}, r_data, 4'hf, 3'b000),
                  1'b0, '0, '0, 1'b1, 1'b0);
      read_check(r_index[3:0]);
    end

    current_test = "busy";
    for (int i = 0; i < BUSY_ROUNDS; i++) begin
      take_bits(4, r_index);
      take_bits(32, r_data);
      do_transfer(make_command(1'b0, {26'd0, r_index[3:0], 2'b00}, '0, 4'h0, 3'b001), 1'b1,
                  make_command(1'b1, {26'd0, r_index[3:0], 2'b00}, r_data, 4'hf, 3'b001),
                  model[r_index[3:0]], 1'b0, 1'b1);
      read_check(r_index[3:0]);
    end

    @(negedge clock);
    $display("transfers: %0d errors: %0d", transfers, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: verilog/apb_command_master.sv
`timescale 1ns/1ps

module apb_command_master (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  start,
  input  apb_pkg::command_t     command,
  output logic                  busy,
  output logic                  done,
  output apb_pkg::result_t      result,
  output apb_pkg::apb_request_t request,
  input  apb_pkg::apb_response_t response
);

  typedef enum logic [1:0] {
    state_idle   = 2'd0,
    state_setup  = 2'd1,
    state_access = 2'd2
  } master_state_t;

  master_state_t     state;
  apb_pkg::command_t held_command;
  logic              accept;

  // the done cycle still counts as busy
  assign busy   = (state != state_idle) || done;
  assign accept = start && !busy;

  always_ff @(posedge clock) begin
    if (reset) begin
      state  <= state_idle;
      done   <= 1'b0;
      result <= '0;
    end else begin
      done <= 1'b0;
      case (state)
        state_idle: begin
          if (accept) begin
            state <= state_setup;
          end
        end
        state_setup: begin
          state <= state_access;
        end
        state_access: begin
          if (response.pready) begin
            state        <= state_idle;
            done         <= 1'b1;
            result.rdata <= response.prdata;
            result.error <= response.pslverr;
          end
        end
        default: begin
          state <= state_idle;
        end
      endcase
    end
  end

  // command payload, held for the whole transfer
  always_ff @(posedge clock) begin
    if (accept) begin
      held_command <= command;
    end
  end

  always_comb begin
    request.paddr   = held_command.addr;
    request.psel    = (state != state_idle);
    request.penable = (state == state_access);
    request.pprot   = held_command.prot;
    request.pwrite  = held_command.write;
    request.pwdata  = held_command.wdata;
    request.pstrb   = held_command.strb;
  end

endmodule

// File: verilog/apb_delay_subsystem.sv
`timescale 1ns/1ps

module apb_delay_subsystem #(
  parameter int unsigned RATIO       = 5191,
  parameter int          WAIT_STATES = 2,
  parameter int          REG_COUNT   = 16
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              start,
  input  apb_pkg::command_t command,
  output logic              busy,
  output logic              done,
  output apb_pkg::result_t  result
);

  apb_pkg::apb_request_t  cpu_request;
  apb_pkg::apb_response_t cpu_response;
  apb_pkg::apb_request_t  device_request;
  apb_pkg::apb_response_t device_response;

  apb_command_master master (
    .clock    (clock),
    .reset    (reset),
    .start    (start),
    .command  (command),
    .busy     (busy),
    .done     (done),
    .result   (result),
    .request  (cpu_request),
    .response (cpu_response)
  );

  // stretches each response to core time
  apb_delayer #(
    .RATIO (delay_pkg::accum_t'(RATIO))
  ) delayer (
    .clock           (clock),
    .reset           (reset),
    .cpu_request     (cpu_request),
    .cpu_response    (cpu_response),
    .device_request  (device_request),
    .device_response (device_response)
  );

  apb_register_file #(
    .WAIT_STATES (WAIT_STATES),
    .REG_COUNT   (REG_COUNT)
  ) register_file (
    .clock    (clock),
    .reset    (reset),
    .request  (device_request),
    .response (device_response)
  );

endmodule

// File: verilog/apb_delayer.sv
`timescale 1ns/1ps

module apb_delayer #(
  // core to bus clock ratio, Q10
  parameter delay_pkg::accum_t RATIO = 5191
) (
  input  logic                   clock,
  input  logic                   reset,
  input  apb_pkg::apb_request_t  cpu_request,
  output apb_pkg::apb_response_t cpu_response,
  output apb_pkg::apb_request_t  device_request,
  input  apb_pkg::apb_response_t device_response
);

  delay_pkg::delay_state_t state;
  delay_pkg::accum_t       accum;
  delay_pkg::count_t       count;
  delay_pkg::count_t       target;
  apb_pkg::data_t          rdata_latch;
  logic                    error_latch;
  logic                    release_now;

  // whole core cycles owed for the device time
  assign target      = accum[$bits(delay_pkg::accum_t)-1:delay_pkg::FRAC_BITS];
  assign release_now = (state == delay_pkg::state_delay) && (count == target);

  always_ff @(posedge clock) begin
    if (reset) begin
      state       <= delay_pkg::state_idle;
      accum       <= '0;
      count       <= '0;
      rdata_latch <= '0;
      error_latch <= 1'b0;
    end else begin
      case (state)
        delay_pkg::state_idle: begin
          if (cpu_request.psel && cpu_request.penable) begin
            state <= delay_pkg::state_wait;
            accum <= '0;
          end
        end
        delay_pkg::state_wait: begin
          // the pready cycle is counted too
          accum <= accum + RATIO;
          if (device_response.pready) begin
            state       <= delay_pkg::state_delay;
            count       <= '0;
            rdata_latch <= device_response.prdata;
            error_latch <= device_response.pslverr;
          end
        end
        delay_pkg::state_delay: begin
          count <= count + 1'b1;
          if (release_now) begin
            state <= delay_pkg::state_idle;
            count <= '0;
          end
        end
        default: begin
          state <= delay_pkg::state_idle;
          accum <= '0;
          count <= '0;
        end
      endcase
    end
  end

  // device sees the request except while the response is held back
  always_comb begin
    device_request         = cpu_request;
    device_request.psel    = cpu_request.psel && (state != delay_pkg::state_delay);
    device_request.penable = cpu_request.penable && (state != delay_pkg::state_delay);
  end

  always_comb begin
    cpu_response.pready  = release_now;
    cpu_response.prdata  = rdata_latch;
    cpu_response.pslverr = error_latch;
  end

endmodule

// File: verilog/apb_pkg.sv
package apb_pkg;

  // bus field widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  // bit 0 marks a privileged access
  typedef logic [2:0]  prot_t;

  // driven by a bus master
  typedef struct packed {
    addr_t paddr;
    logic  psel;
    logic  penable;
    prot_t pprot;
    logic  pwrite;
    data_t pwdata;
    strb_t pstrb;
  } apb_request_t;

  // driven by a bus slave
  typedef struct packed {
    logic  pready;
    data_t prdata;
    logic  pslverr;
  } apb_response_t;

  // single-cycle command from the core
  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t wdata;
    strb_t strb;
    prot_t prot;
  } command_t;

  // valid while done is high
  typedef struct packed {
    data_t rdata;
    logic  error;
  } result_t;

endpackage

// File: verilog/apb_register_file.sv
`timescale 1ns/1ps

module apb_register_file #(
  // at least 1
  parameter int WAIT_STATES = 2,
  parameter int REG_COUNT   = 16
) (
  input  logic                   clock,
  input  logic                   reset,
  input  apb_pkg::apb_request_t  request,
  output apb_pkg::apb_response_t response
);

  localparam int INDEX_BITS = $clog2(REG_COUNT);
  localparam int WAIT_BITS  = $clog2(WAIT_STATES + 1);

  apb_pkg::data_t         registers [REG_COUNT];
  logic [WAIT_BITS-1:0]   wait_count;
  logic [INDEX_BITS-1:0]  index;
  logic                   access;
  logic                   complete;
  logic                   in_range;
  logic                   privileged;
  logic                   denied;

  assign access     = request.psel && request.penable;
  assign complete   = access && (wait_count == WAIT_BITS'(WAIT_STATES));
  // word index sits above the byte offset
  assign in_range   = (request.paddr[31:2] < REG_COUNT);
  assign index      = request.paddr[INDEX_BITS+1:2];
  assign privileged = request.pprot[0];
  assign denied     = !in_range || (request.pwrite && !privileged);

  // consecutive access cycles, cleared once the phase ends
  always_ff @(posedge clock) begin
    if (reset) begin
      wait_count <= '0;
    end else if (access && !complete) begin
      wait_count <= wait_count + 1'b1;
    end else begin
      wait_count <= '0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        registers[i] <= '0;
      end
    end else if (complete && request.pwrite && !denied) begin
      for (int b = 0; b < $bits(apb_pkg::strb_t); b++) begin
        if (request.pstrb[b]) begin
          registers[index][8*b +: 8] <= request.pwdata[8*b +: 8];
        end
      end
    end
  end

  always_comb begin
    response.pready  = complete;
    response.pslverr = complete && denied;
    // out of range reads return zero
    if (in_range) begin
      response.prdata = registers[index];
    end else begin
      response.prdata = '0;
    end
  end

endmodule

// File: verilog/delay_pkg.sv
package delay_pkg;

  // ratio is fixed point with this many fraction bits
  localparam int FRAC_BITS = 10;

  // scaled device time
  typedef logic [31:0] accum_t;

  // integer part of the accumulator
  typedef logic [$bits(accum_t)-FRAC_BITS-1:0] count_t;

  typedef enum logic [1:0] {
    state_idle  = 2'd0,
    state_wait  = 2'd1,
    state_delay = 2'd2
  } delay_state_t;

endpackage
